/* common/ctrlConsts.svh */
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// Opcodes
`define CTRL_OP_RTYPE          6'b000000
`define CTRL_OP_ADDI           6'b001000
`define CTRL_OP_ADDIU          6'b001001

// R-type funct field
`define CTRL_FN_ADD            6'b100000
`define CTRL_FN_AND            6'b100100
`define CTRL_FN_SUB            6'b100010
`define CTRL_FN_SLL            6'b000000

// Multi-cycle step lengths
`define CTRL_FETCH_CYCLES      4
`define CTRL_SHIFT_CYCLES      3

// ALU function
`define CTRL_ALU_ADD           3'b001
`define CTRL_ALU_SUB           3'b010
`define CTRL_ALU_AND           3'b011
`define CTRL_ALU_PASS          3'b100

// ALU operand muxes
`define CTRL_SRCA_PC           2'b00
`define CTRL_SRCA_REGA         2'b01
`define CTRL_SRCB_REGB         3'b000
`define CTRL_SRCB_FOUR         3'b001
`define CTRL_SRCB_SHIFTED_IMM  3'b010  // Branch offset, word aligned
`define CTRL_SRCB_SIGNEXT_IMM  3'b011

`define CTRL_MEMADDR_PC        3'b010

`define CTRL_PCSRC_ALU_RESULT  2'b00
`define CTRL_PCSRC_ALUOUT_REG  2'b10

// Register file write port
`define CTRL_REGDST_RD         2'b00
`define CTRL_REGDST_STACK      2'b01  // Stack pointer, loaded at power-up
`define CTRL_REGDST_RT         2'b11
`define CTRL_WDATA_ALUOUT      3'b000
`define CTRL_WDATA_STACK_INIT  3'b011
`define CTRL_WDATA_SHIFT       3'b110

// Shifter
`define CTRL_SHIFT_HOLD        3'b000
`define CTRL_SHIFT_LOAD        3'b001
`define CTRL_SHIFT_LEFT        3'b010
`define CTRL_SHAMT_NONE        2'b00
`define CTRL_SHAMT_FIELD       2'b10

`endif

/* common/ctrlPkg.sv */
`include "ctrlConsts.svh"

package ctrlPkg;

    typedef enum logic [2:0] {
        aluAdd  = `CTRL_ALU_ADD,
        aluSub  = `CTRL_ALU_SUB,
        aluAnd  = `CTRL_ALU_AND,
        aluPass = `CTRL_ALU_PASS
    } aluOpT;

    typedef enum logic [1:0] {
        srcAPc   = `CTRL_SRCA_PC,
        srcARegA = `CTRL_SRCA_REGA
    } aluSrcAT;

    typedef enum logic [2:0] {
        srcBRegB       = `CTRL_SRCB_REGB,
        srcBFour       = `CTRL_SRCB_FOUR,
        srcBShiftedImm = `CTRL_SRCB_SHIFTED_IMM,
        srcBSignExtImm = `CTRL_SRCB_SIGNEXT_IMM
    } aluSrcBT;

    typedef enum logic [2:0] {
        memAddrPc = `CTRL_MEMADDR_PC
    } memAddrSelT;

    typedef enum logic [1:0] {
        pcSrcAluResult = `CTRL_PCSRC_ALU_RESULT,
        pcSrcAluOutReg = `CTRL_PCSRC_ALUOUT_REG
    } pcSrcT;

    typedef enum logic [1:0] {
        regDstRd    = `CTRL_REGDST_RD,
        regDstStack = `CTRL_REGDST_STACK,
        regDstRt    = `CTRL_REGDST_RT
    } regDstT;

    typedef enum logic [2:0] {
        wdAluOut      = `CTRL_WDATA_ALUOUT,
        wdStackInit   = `CTRL_WDATA_STACK_INIT,
        wdShiftResult = `CTRL_WDATA_SHIFT
    } writeDataSelT;

    typedef enum logic [2:0] {
        shiftHold = `CTRL_SHIFT_HOLD,
        shiftLoad = `CTRL_SHIFT_LOAD,
        shiftLeft = `CTRL_SHIFT_LEFT
    } shiftOpT;

    typedef enum logic [1:0] {
        shiftAmtNone  = `CTRL_SHAMT_NONE,
        shiftAmtShamt = `CTRL_SHAMT_FIELD
    } shiftAmtSelT;

    typedef struct packed {
        logic         pcWrite;
        logic         aWrite;
        logic         bWrite;
        logic         aluOutWrite;
        logic         memWrite;
        logic         irWrite;
        logic         regWrite;
        logic         shiftSrc;
        memAddrSelT   memAddrSel;
        aluSrcAT      aluSrcA;
        aluSrcBT      aluSrcB;
        aluOpT        aluOp;
        pcSrcT        pcSrc;
        regDstT       regDst;
        writeDataSelT writeDataSel;
        shiftOpT      shiftOp;
        shiftAmtSelT  shiftAmtSel;
    } controlWordT;

    typedef enum logic [2:0] {
        opAdd, opAnd, opSub, opSll, opAddi, opAddiu, opBad
    } opClassT;

    typedef enum logic [3:0] {
        Init, Fetch, Precalc, Precalc2, ExecAlu, ExecImm, SaveResult,
        ImmWriteback, ShiftSeq, TrapOverflow, TrapOpcode
    } stepT;

    typedef enum logic [1:0] {
        trapNone, trapOverflow, trapBadOpcode
    } trapT;

    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    // Low halfword of the instruction, R-type fields or I-type immediate
    typedef union packed {
        rFieldsT     r;
        logic [15:0] imm;
    } instrLowT;

endpackage

/* control/controlWordGen.sv */
`timescale 1ns/1ps

module controlWordGen (
    input  ctrlPkg::stepT        step,
    input  logic [1:0]           subStep,
    input  ctrlPkg::opClassT     execClass,
    output ctrlPkg::controlWordT ctrl
);

    ctrlPkg::aluOpT   execAluOp;
    ctrlPkg::aluSrcBT execSrcB;

    always_comb begin
        case (execClass)
            ctrlPkg::opSub: execAluOp = ctrlPkg::aluSub;
            ctrlPkg::opAnd: execAluOp = ctrlPkg::aluAnd;
            default:        execAluOp = ctrlPkg::aluAdd;  // add, addi, addiu
        endcase
    end

    assign execSrcB = (execClass inside {ctrlPkg::opAddi, ctrlPkg::opAddiu}) ?
                      ctrlPkg::srcBSignExtImm : ctrlPkg::srcBRegB;

    always_comb begin
        // Idle word, no write enable set
        ctrl.pcWrite      = 1'b0;
        ctrl.aWrite       = 1'b0;
        ctrl.bWrite       = 1'b0;
        ctrl.aluOutWrite  = 1'b0;
        ctrl.memWrite     = 1'b0;
        ctrl.irWrite      = 1'b0;
        ctrl.regWrite     = 1'b0;
        ctrl.shiftSrc     = 1'b0;
        ctrl.memAddrSel   = ctrlPkg::memAddrPc;
        ctrl.aluSrcA      = ctrlPkg::srcAPc;
        ctrl.aluSrcB      = ctrlPkg::srcBRegB;
        ctrl.aluOp        = ctrlPkg::aluAdd;
        ctrl.pcSrc        = ctrlPkg::pcSrcAluOutReg;
        ctrl.regDst       = ctrlPkg::regDstRd;
        ctrl.writeDataSel = ctrlPkg::wdAluOut;
        ctrl.shiftOp      = ctrlPkg::shiftHold;
        ctrl.shiftAmtSel  = ctrlPkg::shiftAmtNone;

        case (step)
            ctrlPkg::Init: begin
                ctrl.regWrite     = 1'b1;
                ctrl.regDst       = ctrlPkg::regDstStack;
                ctrl.writeDataSel = ctrlPkg::wdStackInit;
            end
            ctrlPkg::Fetch: begin
                if (subStep == 2'd3) begin
                    ctrl.pcWrite = 1'b1;  // PC <= ALUOut (pc + 4)
                end else begin
                    ctrl.irWrite     = 1'b1;
                    ctrl.aluOutWrite = 1'b1;
                    ctrl.aluSrcB     = ctrlPkg::srcBFour;
                end
            end
            ctrlPkg::Precalc: begin
                // Speculative branch target
                ctrl.aluOutWrite = 1'b1;
                ctrl.aluSrcB     = ctrlPkg::srcBShiftedImm;
            end
            ctrlPkg::Precalc2: begin
                ctrl.aWrite = 1'b1;
                ctrl.bWrite = 1'b1;
            end
            ctrlPkg::ExecAlu, ctrlPkg::ExecImm: begin
                ctrl.aluOutWrite = 1'b1;
                ctrl.aluSrcA     = ctrlPkg::srcARegA;
                ctrl.aluSrcB     = execSrcB;
                ctrl.aluOp       = execAluOp;
            end
            ctrlPkg::SaveResult: begin
                ctrl.regWrite = 1'b1;
            end
            ctrlPkg::ImmWriteback: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = ctrlPkg::regDstRt;
            end
            ctrlPkg::ShiftSeq: begin
                ctrl.aluSrcA     = ctrlPkg::srcARegA;
                ctrl.aluOp       = ctrlPkg::aluPass;
                ctrl.shiftAmtSel = ctrlPkg::shiftAmtShamt;
                ctrl.shiftOp     = (subStep == 2'd0) ? ctrlPkg::shiftLoad : ctrlPkg::shiftLeft;
                if (subStep == 2'd2) begin
                    ctrl.regWrite     = 1'b1;
                    ctrl.writeDataSel = ctrlPkg::wdShiftResult;
                end
            end
            default: begin
            end
        endcase

        // IR and register file share the fetch bus timing
        assert (!(ctrl.irWrite && ctrl.regWrite))
            else $error("irWrite and regWrite both set in step %s", step.name());
    end

endmodule

/* control/opDecoder.sv */
`timescale 1ns/1ps
`include "ctrlConsts.svh"

module opDecoder (
    input  logic [5:0]        opcode,
    input  ctrlPkg::instrLowT instrLow,
    output ctrlPkg::opClassT  opClass
);

    ctrlPkg::opClassT rClass;

    // Funct decode, only meaningful for R-type opcodes
    always_comb begin
        case (instrLow.r.funct)
            `CTRL_FN_ADD: begin
                rClass = ctrlPkg::opAdd;
            end
            `CTRL_FN_AND: begin
                rClass = ctrlPkg::opAnd;
            end
            `CTRL_FN_SUB: begin
                rClass = ctrlPkg::opSub;
            end
            `CTRL_FN_SLL: begin
                rClass = ctrlPkg::opSll;
            end
            default: begin
                rClass = ctrlPkg::opBad;  // mult, div, jr, other shifts...
            end
        endcase
    end

    always_comb begin
        case (opcode)
            `CTRL_OP_RTYPE: begin
                opClass = rClass;
            end
            `CTRL_OP_ADDI: begin
                opClass = ctrlPkg::opAddi;
            end
            `CTRL_OP_ADDIU: begin
                opClass = ctrlPkg::opAddiu;
            end
            // Loads, stores, branches and jumps are not supported
            default: begin
                opClass = ctrlPkg::opBad;
            end
        endcase
    end

endmodule

/* control/stepSequencer.sv */
`timescale 1ns/1ps
`include "ctrlConsts.svh"

module stepSequencer (
    input  logic             clk,
    input  logic             reset,
    input  ctrlPkg::opClassT opClass,
    input  logic             overflow,
    output ctrlPkg::stepT    step,
    output logic [1:0]       subStep,
    output ctrlPkg::opClassT execClass,
    output ctrlPkg::trapT    trap
);

    localparam logic [1:0] fetchLast = 2'(`CTRL_FETCH_CYCLES - 1);
    localparam logic [1:0] shiftLast = 2'(`CTRL_SHIFT_CYCLES - 1);

    ctrlPkg::stepT nextStep;
    ctrlPkg::stepT execStep;
    logic [1:0]    nextSubStep;

    // First execute step for the freshly decoded instruction
    always_comb begin
        case (opClass)
            ctrlPkg::opAdd, ctrlPkg::opAnd, ctrlPkg::opSub: begin
                execStep = ctrlPkg::ExecAlu;
            end
            ctrlPkg::opAddi, ctrlPkg::opAddiu: begin
                execStep = ctrlPkg::ExecImm;
            end
            ctrlPkg::opSll: begin
                execStep = ctrlPkg::ShiftSeq;
            end
            default: begin
                execStep = ctrlPkg::TrapOpcode;
            end
        endcase
    end

    always_comb begin
        nextStep    = step;
        nextSubStep = 2'd0;
        case (step)
            ctrlPkg::Init: begin
                nextStep = ctrlPkg::Fetch;
            end
            ctrlPkg::Fetch: begin
                if (subStep == fetchLast) begin
                    nextStep = ctrlPkg::Precalc;
                end else begin
                    nextSubStep = subStep + 2'd1;
                end
            end
            ctrlPkg::Precalc: begin
                nextStep = ctrlPkg::Precalc2;
            end
            ctrlPkg::Precalc2: begin
                nextStep = execStep;
            end
            ctrlPkg::ExecAlu: begin
                nextStep = ctrlPkg::SaveResult;
            end
            ctrlPkg::SaveResult: begin
                nextStep = overflow ? ctrlPkg::TrapOverflow : ctrlPkg::Fetch;
            end
            ctrlPkg::ExecImm: begin
                // addiu never traps
                if (overflow && execClass == ctrlPkg::opAddi) begin
                    nextStep = ctrlPkg::TrapOverflow;
                end else begin
                    nextStep = ctrlPkg::ImmWriteback;
                end
            end
            ctrlPkg::ImmWriteback: begin
                nextStep = ctrlPkg::Fetch;
            end
            ctrlPkg::ShiftSeq: begin
                if (subStep == shiftLast) begin
                    nextStep = ctrlPkg::Fetch;
                end else begin
                    nextSubStep = subStep + 2'd1;
                end
            end
            default: begin
                nextStep = step;  // Traps wait for reset
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step      <= ctrlPkg::Init;
            subStep   <= 2'd0;
            execClass <= ctrlPkg::opAdd;
        end else begin
            step    <= nextStep;
            subStep <= nextSubStep;
            if (step == ctrlPkg::Precalc2) begin
                execClass <= opClass;
            end
        end
    end

    always_comb begin
        case (step)
            ctrlPkg::TrapOverflow: trap = ctrlPkg::trapOverflow;
            ctrlPkg::TrapOpcode:   trap = ctrlPkg::trapBadOpcode;
            default:               trap = ctrlPkg::trapNone;
        endcase
    end

    // Sub-step only counts inside the multi-cycle steps
    aSubStepRange: assert property (@(posedge clk) disable iff (reset)
        (step == ctrlPkg::ShiftSeq |-> subStep <= shiftLast) and
        (!(step inside {ctrlPkg::Fetch, ctrlPkg::ShiftSeq}) |-> subStep == 2'd0))
        else $error("subStep out of range in step %s", step.name());

    aTrapHolds: assert property (@(posedge clk) disable iff (reset)
        step inside {ctrlPkg::TrapOverflow, ctrlPkg::TrapOpcode} |=> step == $past(step))
        else $error("trap step left without reset");

    aBadOnlyInTrap: assert property (@(posedge clk) disable iff (reset)
        execClass == ctrlPkg::opBad |-> step == ctrlPkg::TrapOpcode)
        else $error("bad opcode class reached step %s", step.name());

endmodule

/* ctrlUnit.f */
+incdir+common
common/ctrlPkg.sv
control/opDecoder.sv
control/stepSequencer.sv
control/controlWordGen.sv
design/ctrlUnit.sv
tb/tbClock.sv
tb/ctrlUnitTb.sv

/* design/ctrlUnit.sv */
`timescale 1ns/1ps

module ctrlUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [5:0]           opcode,
    input  ctrlPkg::instrLowT    instrLow,
    input  logic                 overflow,
    output ctrlPkg::controlWordT ctrl,
    output ctrlPkg::trapT        trap
);

    ctrlPkg::opClassT opClass;    // Live decode of the IR
    ctrlPkg::opClassT execClass;  // Held from Precalc2
    ctrlPkg::stepT    step;
    logic [1:0]       subStep;

    opDecoder decoder (
        .opcode   (opcode),
        .instrLow (instrLow),
        .opClass  (opClass)
    );

    stepSequencer sequencer (
        .clk       (clk),
        .reset     (reset),
        .opClass   (opClass),
        .overflow  (overflow),
        .step      (step),
        .subStep   (subStep),
        .execClass (execClass),
        .trap      (trap)
    );

    // Moore outputs, depend only on registered state
    controlWordGen wordGen (
        .step      (step),
        .subStep   (subStep),
        .execClass (execClass),
        .ctrl      (ctrl)
    );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ctrlUnitTb \
    -f ctrlUnit.f -o ctrlUnitSim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/ctrlUnitSim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation ended early"; exit 1; }
exit 0

/* tb/ctrlUnitTb.sv */
`timescale 1ns/1ps
`include "ctrlConsts.svh"

module ctrlUnitTb;

    localparam int numInstr       = 2000;
    localparam int resetCycles    = 16;
    localparam int trapHoldCycles = 3;
    localparam int maxInstrCycles = 9;   // sll
    localparam int clkPeriodNs    = 10;
    localparam longint timeoutNs  = longint'(numInstr) *
        (maxInstrCycles + resetCycles + trapHoldCycles + 4) * clkPeriodNs;

    logic                 clk;
    logic                 reset;
    logic [5:0]           opcode;
    ctrlPkg::instrLowT    instrLow;
    logic                 overflow;
    ctrlPkg::controlWordT ctrl;
    ctrlPkg::trapT        trap;

    // Cycle model state
    ctrlPkg::stepT    mStep = ctrlPkg::Init;
    logic [1:0]       mSub = 2'd0;
    ctrlPkg::opClassT mClass = ctrlPkg::opAdd;
    logic             modelValid = 1'b0;

    int classCount [7];
    int aluTraps = 0;
    int immTraps = 0;
    int drawn = 0;

    tbClock clockGen (.clk(clk));

    ctrlUnit i_dut (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .instrLow (instrLow),
        .overflow (overflow),
        .ctrl     (ctrl),
        .trap     (trap)
    );

    function automatic ctrlPkg::opClassT decodeClass(logic [5:0] op, logic [5:0] fn);
        if (op == `CTRL_OP_ADDI) return ctrlPkg::opAddi;
        if (op == `CTRL_OP_ADDIU) return ctrlPkg::opAddiu;
        if (op != `CTRL_OP_RTYPE) return ctrlPkg::opBad;
        if (fn == `CTRL_FN_ADD) return ctrlPkg::opAdd;
        if (fn == `CTRL_FN_AND) return ctrlPkg::opAnd;
        if (fn == `CTRL_FN_SUB) return ctrlPkg::opSub;
        if (fn == `CTRL_FN_SLL) return ctrlPkg::opSll;
        return ctrlPkg::opBad;
    endfunction

    function automatic ctrlPkg::controlWordT expectedWord(ctrlPkg::stepT s, logic [1:0] sub,
                                                          ctrlPkg::opClassT cls);
        ctrlPkg::controlWordT w;
        w = '0;
        w.memAddrSel = ctrlPkg::memAddrPc;
        w.pcSrc      = ctrlPkg::pcSrcAluOutReg;
        w.aluOp      = ctrlPkg::aluAdd;
        if (s == ctrlPkg::Init) begin
            w.regWrite     = 1'b1;
            w.regDst       = ctrlPkg::regDstStack;
            w.writeDataSel = ctrlPkg::wdStackInit;
        end else if (s == ctrlPkg::Fetch && sub == 2'(`CTRL_FETCH_CYCLES - 1)) begin
            w.pcWrite = 1'b1;
        end else if (s == ctrlPkg::Fetch) begin
            w.irWrite     = 1'b1;
            w.aluOutWrite = 1'b1;
            w.aluSrcB     = ctrlPkg::srcBFour;  // pc + 4
        end else if (s == ctrlPkg::Precalc) begin
            w.aluOutWrite = 1'b1;
            w.aluSrcB     = ctrlPkg::srcBShiftedImm;
        end else if (s == ctrlPkg::Precalc2) begin
            w.aWrite = 1'b1;
            w.bWrite = 1'b1;
        end else if (s == ctrlPkg::ExecAlu) begin
            w.aluOutWrite = 1'b1;
            w.aluSrcA     = ctrlPkg::srcARegA;
            if (cls == ctrlPkg::opSub) w.aluOp = ctrlPkg::aluSub;
            else if (cls == ctrlPkg::opAnd) w.aluOp = ctrlPkg::aluAnd;
        end else if (s == ctrlPkg::ExecImm) begin
            w.aluOutWrite = 1'b1;
            w.aluSrcA     = ctrlPkg::srcARegA;
            w.aluSrcB     = ctrlPkg::srcBSignExtImm;
        end else if (s == ctrlPkg::SaveResult) begin
            w.regWrite = 1'b1;
        end else if (s == ctrlPkg::ImmWriteback) begin
            w.regWrite = 1'b1;
            w.regDst   = ctrlPkg::regDstRt;
        end else if (s == ctrlPkg::ShiftSeq) begin
            w.aluSrcA     = ctrlPkg::srcARegA;
            w.aluOp       = ctrlPkg::aluPass;
            w.shiftAmtSel = ctrlPkg::shiftAmtShamt;
            w.shiftOp     = (sub == 2'd0) ? ctrlPkg::shiftLoad : ctrlPkg::shiftLeft;
            if (sub == 2'd2) begin
                w.regWrite     = 1'b1;
                w.writeDataSel = ctrlPkg::wdShiftResult;
            end
        end
        return w;  // Trap steps keep the idle word
    endfunction

    function automatic ctrlPkg::trapT expectedTrap(ctrlPkg::stepT s);
        if (s == ctrlPkg::TrapOverflow) return ctrlPkg::trapOverflow;
        if (s == ctrlPkg::TrapOpcode) return ctrlPkg::trapBadOpcode;
        return ctrlPkg::trapNone;
    endfunction

    task automatic checkCtrl(ctrlPkg::controlWordT exp, ctrlPkg::controlWordT act);
        if (act !== exp) begin
            $display("Fail ctrl: expected %h, actual %h (step %s, subStep %0d)",
                     exp, act, mStep.name(), mSub);
            $display("TESTBENCH FAILED");
            $fatal(1, "control word mismatch");
        end
    endtask

    task automatic checkTrap(ctrlPkg::trapT exp, ctrlPkg::trapT act);
        if (act !== exp) begin
            $display("Fail trap: expected %h, actual %h (step %s)", exp, act, mStep.name());
            $display("TESTBENCH FAILED");
            $fatal(1, "trap mismatch");
        end
    endtask

    task automatic advanceModel;
        case (mStep)
            ctrlPkg::Init: mStep = ctrlPkg::Fetch;
            ctrlPkg::Fetch: begin
                if (mSub == 2'(`CTRL_FETCH_CYCLES - 1)) begin
                    mStep = ctrlPkg::Precalc;
                    mSub  = 2'd0;
                end else begin
                    mSub = mSub + 2'd1;
                end
            end
            ctrlPkg::Precalc: mStep = ctrlPkg::Precalc2;
            ctrlPkg::Precalc2: begin
                mClass = decodeClass(opcode, instrLow.r.funct);
                classCount[int'(mClass)]++;
                case (mClass)
                    ctrlPkg::opSll:                    mStep = ctrlPkg::ShiftSeq;
                    ctrlPkg::opAddi, ctrlPkg::opAddiu: mStep = ctrlPkg::ExecImm;
                    ctrlPkg::opBad:                    mStep = ctrlPkg::TrapOpcode;
                    default:                           mStep = ctrlPkg::ExecAlu;
                endcase
            end
            ctrlPkg::ExecAlu: mStep = ctrlPkg::SaveResult;
            ctrlPkg::SaveResult: begin
                mStep = overflow ? ctrlPkg::TrapOverflow : ctrlPkg::Fetch;
                aluTraps += overflow;
            end
            ctrlPkg::ExecImm: begin
                if (overflow && mClass == ctrlPkg::opAddi) begin
                    mStep = ctrlPkg::TrapOverflow;
                    immTraps++;
                end else begin
                    mStep = ctrlPkg::ImmWriteback;
                end
            end
            ctrlPkg::ImmWriteback: mStep = ctrlPkg::Fetch;
            ctrlPkg::ShiftSeq: begin
                mStep = (mSub == 2'd2) ? ctrlPkg::Fetch : ctrlPkg::ShiftSeq;
                mSub  = (mSub == 2'd2) ? 2'd0 : mSub + 2'd1;
            end
            default: mStep = mStep;  // Trap until reset
        endcase
    endtask

    // Check the cycle that just ended, then step the model
    always @(posedge clk) begin
        if (modelValid) begin
            checkCtrl(expectedWord(mStep, mSub, mClass), ctrl);
            checkTrap(expectedTrap(mStep), trap);
        end
        if (reset) begin
            mStep      = ctrlPkg::Init;
            mSub       = 2'd0;
            modelValid = 1'b1;
        end else if (modelValid) begin
            advanceModel();
        end
    end

    task automatic applyReset;
        reset = 1'b1;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic drawInstr;
        int unsigned pick;
        pick = $urandom % 100;
        instrLow.imm = 16'($urandom);  // Random rd, shamt or immediate
        opcode = `CTRL_OP_RTYPE;
        if (pick < 85) begin
            case (pick % 6)
                0: instrLow.r.funct = `CTRL_FN_ADD;
                1: instrLow.r.funct = `CTRL_FN_AND;
                2: instrLow.r.funct = `CTRL_FN_SUB;
                3: instrLow.r.funct = `CTRL_FN_SLL;
                4: opcode = `CTRL_OP_ADDI;
                default: opcode = `CTRL_OP_ADDIU;
            endcase
        end else if (pick < 92) begin
            while (instrLow.r.funct inside {`CTRL_FN_ADD, `CTRL_FN_AND, `CTRL_FN_SUB,
                                            `CTRL_FN_SLL}) begin
                instrLow.r.funct = 6'($urandom);
            end
        end else begin
            while (opcode inside {`CTRL_OP_RTYPE, `CTRL_OP_ADDI, `CTRL_OP_ADDIU}) begin
                opcode = 6'($urandom);
            end
        end
    endtask

    function automatic bit allCasesSeen();
        foreach (classCount[i]) begin
            if (classCount[i] == 0) return 1'b0;
        end
        return aluTraps > 0 && immTraps > 0;
    endfunction

    initial begin
        void'($urandom(32'h952a));
        reset    = 1'b1;
        opcode   = 6'd0;
        instrLow = '0;
        overflow = 1'b0;
        applyReset();
        while (drawn < numInstr) begin
            @(negedge clk);
            overflow = (($urandom % 10) == 0);
            if (mStep inside {ctrlPkg::TrapOverflow, ctrlPkg::TrapOpcode}) begin
                repeat (trapHoldCycles) @(negedge clk);  // Trap must hold
                applyReset();
            end else if (mStep == ctrlPkg::Fetch && mSub == 2'd0) begin
                drawInstr();
                drawn++;
            end
        end
        // Let the last instruction finish
        do begin
            @(negedge clk);
        end while (!(mStep == ctrlPkg::Fetch && mSub == 2'd0) &&
                   !(mStep inside {ctrlPkg::TrapOverflow, ctrlPkg::TrapOpcode}));
        if (allCasesSeen()) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Not every instruction class and trap cause was exercised");
            $display("TESTBENCH FAILED");
            $fatal(1, "incomplete coverage");
        end
    end

    initial begin
        #(timeoutNs);
        $display("Timeout: the run did not finish within %0d ns", timeoutNs);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* tb/tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
    parameter int halfPeriodNs = 5  // 10 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriodNs) clk = ~clk;
    end

endmodule
